// File: build.f
+incdir+hw
hw/stream_pkg.sv
hw/harness_ctrl_pkg.sv
hw/load_if.sv
hw/msg_source.sv
hw/msg_queue.sv
hw/msg_sink.sv
hw/stream_harness_top.sv
bench/harness_properties.sv
bench/harness_tb.sv

// File: Makefile
# Verilator build and run of the stream harness testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := harness_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/harness_tb.sv
// Table-driven testbench for the source, queue and sink chain
// Each row loads both memories, runs once and checks the sink counters
// Inputs change on the falling edge, outputs are sampled there too
`timescale 1ns/1ps

`include "harness_cfg.svh"

module harness_tb import stream_pkg::*, harness_ctrl_pkg::*; ();

        localparam int NUM_TESTS = 7;

        logic         clk;
        logic         reset;
        logic         load_en;
        load_target_e load_target;
        index_t       load_addr;
        msg_t         load_data;
        logic         start;
        count_t       num_msgs;
        logic         stall_en;
        logic         source_done;
        logic         sink_done;
        count_t       error_count;
        count_t       recv_count;

        stream_harness_top stream_harness_top_inst (.*);

        // 8 ns clock
        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // ----------------------------------------------------------------------
        // Test table, one entry per column array
        // ----------------------------------------------------------------------

        string  t_name    [NUM_TESTS];
        count_t t_num     [NUM_TESTS];
        logic   t_stall   [NUM_TESTS];
        logic   t_random  [NUM_TESTS];
        msg_t   t_base    [NUM_TESTS];
        msg_t   t_step    [NUM_TESTS];
        // Corrupted expected entries, -1 for none
        int     t_bad_a   [NUM_TESTS];
        int     t_bad_b   [NUM_TESTS];
        count_t t_exp_err [NUM_TESTS];

        int          n_rows;
        int          budget_cycles;
        int          fail_count;
        int          tests_failed;
        logic [31:0] lfsr_state;

        function automatic void add_row(input string name, input int num, input logic stall,
                                        input logic rnd, input msg_t base, input msg_t step,
                                        input int bad_a, input int bad_b, input int exp_err);
                t_name[n_rows]    = name;
                t_num[n_rows]     = count_t'(num);
                t_stall[n_rows]   = stall;
                t_random[n_rows]  = rnd;
                t_base[n_rows]    = base;
                t_step[n_rows]    = step;
                t_bad_a[n_rows]   = bad_a;
                t_bad_b[n_rows]   = bad_b;
                t_exp_err[n_rows] = count_t'(exp_err);
                n_rows++;
        endfunction

        function automatic void fill_table();
                n_rows = 0;
                add_row("in_order",           8,  1'b0, 1'b0, 16'h1000, 16'h0001, -1, -1, 0);
                add_row("one_corrupt",        10, 1'b0, 1'b0, 16'h2000, 16'h0011, 3,  -1, 1);
                add_row("two_corrupt",        12, 1'b0, 1'b0, 16'h3000, 16'h0101, 0,  11, 2);
                add_row("stall_random",       40, 1'b1, 1'b1, 16'h0000, 16'h0000, -1, -1, 0);
                add_row("zero_msgs",          0,  1'b0, 1'b0, 16'h0000, 16'h0000, -1, -1, 0);
                add_row("full_memory",        64, 1'b0, 1'b0, 16'h8000, 16'h0003, -1, -1, 0);
                add_row("full_stall_corrupt", 64, 1'b1, 1'b1, 16'h0000, 16'h0000, 63, -1, 1);
        endfunction

        // ----------------------------------------------------------------------
        // Random data, 32-bit Fibonacci LFSR with taps 32 22 2 1
        // ----------------------------------------------------------------------

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        // One LFSR step per message bit
        function automatic msg_t random_msg();
                msg_t m;
                m = '0;
                for (int b = 0; b < `HARNESS_MSG_NBITS; b++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        m = {m[`HARNESS_MSG_NBITS-2:0], lfsr_state[0]};
                end
                return m;
        endfunction

        // One-cycle write strobe on the load port
        task automatic write_word(input load_target_e tgt, input index_t addr, input msg_t data);
                @(negedge clk);
                load_en     = 1'b1;
                load_target = tgt;
                load_addr   = addr;
                load_data   = data;
        endtask

        // ----------------------------------------------------------------------
        // One table row
        // ----------------------------------------------------------------------

        task automatic run_test(input int t);
                msg_t src_list [`HARNESS_MAX_MSGS];
                msg_t exp_list [`HARNESS_MAX_MSGS];
                int   count;
                int   limit;
                int   cycles;
                int   errs;

                count = int'(t_num[t]);
                limit = 8 * count + 20;
                errs  = 0;

                // Source list, expected list with chosen entries inverted
                for (int i = 0; i < count; i++) begin
                        if (t_random[t]) begin
                                src_list[i] = random_msg();
                        end else begin
                                src_list[i] = t_base[t] + msg_t'(i) * t_step[t];
                        end
                        exp_list[i] = src_list[i];
                        if (i == t_bad_a[t] || i == t_bad_b[t]) begin
                                exp_list[i] = ~src_list[i];
                        end
                end

                for (int i = 0; i < count; i++) begin
                        write_word(load_source, index_t'(i), src_list[i]);
                        write_word(load_sink, index_t'(i), exp_list[i]);
                end
                @(negedge clk);
                load_en = 1'b0;

                // Flags of the previous run still held
                if (t > 0 && (!source_done || !sink_done)) begin
                        $display("Test %s: done flags dropped before start", t_name[t]);
                        errs++;
                end

                num_msgs = t_num[t];
                stall_en = t_stall[t];
                start    = 1'b1;
                @(negedge clk);
                start = 1'b0;

                // Cycle after start
                if (count == 0 && (!source_done || !sink_done)) begin
                        $display("Test %s: dones not high the cycle after start", t_name[t]);
                        errs++;
                end else if (count != 0 && (source_done || sink_done)) begin
                        $display("Test %s: done flags did not drop on start", t_name[t]);
                        errs++;
                end

                cycles = 0;
                while (!sink_done && cycles < limit) begin
                        @(negedge clk);
                        cycles++;
                end

                if (!sink_done) begin
                        $display("Test %s: sink_done did not rise within %0d cycles",
                                 t_name[t], limit);
                        errs++;
                end else begin
                        if (!source_done) begin
                                $display("Test %s: source_done low after the sink finished",
                                         t_name[t]);
                                errs++;
                        end
                        if (error_count != t_exp_err[t]) begin
                                $display("Mismatch %s error_count: expected %0d, actual %0d",
                                         t_name[t], t_exp_err[t], error_count);
                                errs++;
                        end
                        if (recv_count != t_num[t]) begin
                                $display("Mismatch %s recv_count: expected %0d, actual %0d",
                                         t_name[t], t_num[t], recv_count);
                                errs++;
                        end
                        // Unstalled chain moves one message per cycle behind two edges
                        // of latency, any sink stall only adds cycles
                        if (count != 0 && !t_stall[t] && cycles != count + 1) begin
                                $display("Mismatch %s cycles: expected %0d, actual %0d",
                                         t_name[t], count + 1, cycles);
                                errs++;
                        end else if (count != 0 && t_stall[t] && cycles <= count + 1) begin
                                $display("Test %s: stall_en caused no back-pressure",
                                         t_name[t]);
                                errs++;
                        end
                end

                if (errs == 0) begin
                        $display("Test %s: passed", t_name[t]);
                end else begin
                        $display("Test %s: failed with %0d errors", t_name[t], errs);
                        tests_failed++;
                end
                fail_count += errs;
        endtask

        // ----------------------------------------------------------------------
        // Main sequence
        // ----------------------------------------------------------------------

        initial begin
                reset        = 1'b0;
                load_en      = 1'b0;
                load_target  = load_source;
                load_addr    = '0;
                load_data    = '0;
                start        = 1'b0;
                num_msgs     = '0;
                stall_en     = 1'b0;
                fail_count   = 0;
                tests_failed = 0;
                lfsr_state   = 32'h6926d89d;
                fill_table();

                // Setup plus per-row allowance
                budget_cycles = 20;
                for (int t = 0; t < NUM_TESTS; t++) begin
                        budget_cycles += 8 * int'(t_num[t]) + 20;
                end

                repeat (4) @(negedge clk);
                reset = 1'b1;
                @(negedge clk);
                if (source_done || sink_done) begin
                        $display("Done flags are high right after reset");
                        fail_count++;
                end

                for (int t = 0; t < NUM_TESTS; t++) begin
                        run_test(t);
                end

                $display("Tests run %0d, tests failed %0d, failed checks %0d",
                         NUM_TESTS, tests_failed, fail_count);
                if (fail_count == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

        // Watchdog, budget is known once the table is filled at time 0
        initial begin
                #1;
                repeat (budget_cycles) @(posedge clk);
                $display("Watchdog expired after %0d cycles, the run did not finish",
                         budget_cycles);
                $display("Simulation failed");
                $finish;
        end

endmodule

// File: bench/harness_properties.sv
// Protocol checks on both stream links and the done flags
// Bound into the top level, all checks are off while reset is low
`timescale 1ns/1ps

module harness_properties import stream_pkg::*; (
        input logic clk,
        input logic reset,
        input logic src_val,
        input logic src_rdy,
        input msg_t src_msg,
        input logic snk_val,
        input logic snk_rdy,
        input msg_t snk_msg,
        input logic start,
        input logic source_done,
        input logic sink_done
);

        // ----------------------------------------------------------------------
        // Handshake signals must be known
        // ----------------------------------------------------------------------

        a_no_x_handshake: assert property (@(posedge clk) disable iff (!reset)
                !$isunknown({src_val, src_rdy, snk_val, snk_rdy}))
                else $error("val or rdy is unknown out of reset");

        // ----------------------------------------------------------------------
        // Stalled transfers hold val and msg
        // ----------------------------------------------------------------------

        // Source to queue
        a_src_hold: assert property (@(posedge clk) disable iff (!reset)
                (src_val && !src_rdy) |=> (src_val && $stable(src_msg)))
                else $error("source link dropped val or changed msg while stalled");

        // Queue to sink
        a_snk_hold: assert property (@(posedge clk) disable iff (!reset)
                (snk_val && !snk_rdy) |=> (snk_val && $stable(snk_msg)))
                else $error("sink link dropped val or changed msg while stalled");

        // Done flags only drop on start
        a_source_done_hold: assert property (@(posedge clk) disable iff (!reset)
                (source_done && !start) |=> source_done)
                else $error("source_done dropped without start");

        a_sink_done_hold: assert property (@(posedge clk) disable iff (!reset)
                (sink_done && !start) |=> sink_done)
                else $error("sink_done dropped without start");

endmodule

bind stream_harness_top harness_properties harness_properties_inst (
        .clk         (clk),
        .reset       (reset),
        .src_val     (src_val),
        .src_rdy     (src_rdy),
        .src_msg     (src_msg),
        .snk_val     (snk_val),
        .snk_rdy     (snk_rdy),
        .snk_msg     (snk_msg),
        .start       (start),
        .source_done (source_done),
        .sink_done   (sink_done)
);

// File: hw/stream_harness_top.sv
// Source, two-entry queue and checking sink joined in one chain
// Load writes and start share one set of plain ports for both memories
// stall_en only affects the sink, the source never pauses on its own
`timescale 1ns/1ps

module stream_harness_top import stream_pkg::*, harness_ctrl_pkg::*; (
        input  logic         clk,
        input  logic         reset,

        // Host load port
        input  logic         load_en,
        input  load_target_e load_target,
        input  index_t       load_addr,
        input  msg_t         load_data,

        // Run control
        input  logic         start,
        input  count_t       num_msgs,
        input  logic         stall_en,

        // Status
        output logic         source_done,
        output logic         sink_done,
        output count_t       error_count,
        output count_t       recv_count
);

        // ----------------------------------------------------------------------
        // Load bus, driven here from the host side
        // ----------------------------------------------------------------------

        load_if load_bus ();

        assign load_bus.en     = load_en;
        assign load_bus.target = load_target;
        assign load_bus.addr   = load_addr;
        assign load_bus.data   = load_data;

        // Stream links
        logic src_val;
        logic src_rdy;
        msg_t src_msg;
        logic snk_val;
        logic snk_rdy;
        msg_t snk_msg;

        // ----------------------------------------------------------------------
        // Chain
        // ----------------------------------------------------------------------

        msg_source msg_source_inst (
                .clk      (clk),
                .reset    (reset),
                .load     (load_bus.mem),
                .start    (start),
                .num_msgs (num_msgs),
                .val      (src_val),
                .rdy      (src_rdy),
                .msg      (src_msg),
                .done     (source_done)
        );

        msg_queue msg_queue_inst (
                .clk     (clk),
                .reset   (reset),
                .in_val  (src_val),
                .in_rdy  (src_rdy),
                .in_msg  (src_msg),
                .out_val (snk_val),
                .out_rdy (snk_rdy),
                .out_msg (snk_msg)
        );

        msg_sink msg_sink_inst (
                .clk         (clk),
                .reset       (reset),
                .load        (load_bus.mem),
                .start       (start),
                .num_msgs    (num_msgs),
                .stall_en    (stall_en),
                .val         (snk_val),
                .rdy         (snk_rdy),
                .msg         (snk_msg),
                .done        (sink_done),
                .error_count (error_count),
                .recv_count  (recv_count)
        );

endmodule

// File: hw/msg_sink.sv
// Stream sink that checks each message against an expected-value memory
// Expected memory is indexed by receive order, entry 0 first
// Counters are valid once done rises and hold until the next start
`timescale 1ns/1ps

`include "harness_cfg.svh"

module msg_sink import stream_pkg::*, harness_ctrl_pkg::*; (
        input  logic   clk,
        input  logic   reset,

        // Memory load port
        load_if.mem    load,

        // Run control, num_msgs sampled on start
        input  logic   start,
        input  count_t num_msgs,
        input  logic   stall_en,

        // Incoming stream
        input  logic   val,
        output logic   rdy,
        input  msg_t   msg,

        // Results
        output logic   done,
        output count_t error_count,
        output count_t recv_count
);

        // ----------------------------------------------------------------------
        // Expected-value memory
        // ----------------------------------------------------------------------

        msg_t        exp_mem [0:`HARNESS_MAX_MSGS-1];

        always_ff @(posedge clk) begin
                if (load.en && load.target == load_sink) begin
                        exp_mem[load.addr] <= load.data;
                end
        end

        // ----------------------------------------------------------------------
        // Random stall source
        // ----------------------------------------------------------------------

        // Fibonacci LFSR, taps 16 14 13 11
        logic [15:0] lfsr;

        always_ff @(posedge clk) begin
                if (!reset) begin
                        lfsr <= `HARNESS_STALL_SEED;
                end else begin
                        lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                end
        end

        // ----------------------------------------------------------------------
        // Receive FSM and counters
        // ----------------------------------------------------------------------

        sink_state_e state;
        count_t      msg_total;
        index_t      recv_index;
        logic        go;
        logic        mismatch;

        // Ready in recv, thinned by the LFSR when stalling
        assign rdy  = (state == snk_recv) && (!stall_en || lfsr[0]);
        assign done = (state == snk_done);
        assign go   = val && rdy;

        // Receive count never reaches full depth while still receiving
        assign recv_index = recv_count[$bits(index_t)-1:0];
        assign mismatch   = (msg != exp_mem[recv_index]);

        always_ff @(posedge clk) begin
                if (start) begin
                        msg_total <= num_msgs;
                end
        end

        always_ff @(posedge clk) begin
                if (!reset) begin
                        state       <= snk_idle;
                        error_count <= '0;
                        recv_count  <= '0;
                end else if (start) begin
                        error_count <= '0;
                        recv_count  <= '0;
                        state       <= (num_msgs == '0) ? snk_done : snk_recv;
                end else if (go) begin
                        recv_count <= recv_count + count_t'(1);
                        if (mismatch) begin
                                error_count <= error_count + count_t'(1);
                        end
                        // Last expected message just arrived
                        if (recv_count + count_t'(1) == msg_total) begin
                                state <= snk_done;
                        end
                end
        end

endmodule

// File: hw/msg_queue.sv
// Two-entry val/rdy queue between source and sink
// No bypass path, a message is seen on the output one cycle after entry
// in_rdy depends on occupancy only, so it is low whenever both slots are full
`timescale 1ns/1ps

module msg_queue import stream_pkg::*; (
        input  logic clk,
        input  logic reset,

        // Upstream side
        input  logic in_val,
        output logic in_rdy,
        input  msg_t in_msg,

        // Downstream side
        output logic out_val,
        input  logic out_rdy,
        output msg_t out_msg
);

        // ----------------------------------------------------------------------
        // Circular buffer state
        // ----------------------------------------------------------------------

        msg_t       entries [0:1];
        logic       wr_ptr;
        logic       rd_ptr;
        // Occupancy 0, 1 or 2
        logic [1:0] occupancy;

        logic enq;
        logic deq;

        assign in_rdy  = (occupancy != 2'd2);
        assign out_val = (occupancy != 2'd0);
        assign out_msg = entries[rd_ptr];

        assign enq = in_val && in_rdy;
        assign deq = out_val && out_rdy;

        // Payload slots carry no reset
        always_ff @(posedge clk) begin
                if (enq) begin
                        entries[wr_ptr] <= in_msg;
                end
        end

        // ----------------------------------------------------------------------
        // Pointers and occupancy
        // ----------------------------------------------------------------------

        always_ff @(posedge clk) begin
                if (!reset) begin
                        wr_ptr    <= 1'b0;
                        rd_ptr    <= 1'b0;
                        occupancy <= 2'd0;
                end else begin
                        if (enq) begin
                                wr_ptr <= ~wr_ptr;
                        end
                        if (deq) begin
                                rd_ptr <= ~rd_ptr;
                        end
                        // Simultaneous enq and deq leave occupancy alone
                        if (enq && !deq) begin
                                occupancy <= occupancy + 2'd1;
                        end else if (deq && !enq) begin
                                occupancy <= occupancy - 2'd1;
                        end
                end
        end

endmodule

// File: hw/msg_source.sv
// Memory-backed stream source, sends num_msgs entries starting at index 0
// Memory holds whatever was last loaded, nothing is cleared on reset
// done stays high after the last transfer until the next start
`timescale 1ns/1ps

`include "harness_cfg.svh"

module msg_source import stream_pkg::*, harness_ctrl_pkg::*; (
        input  logic   clk,
        input  logic   reset,

        // Memory load port
        load_if.mem    load,

        // Run control, num_msgs sampled on start
        input  logic   start,
        input  count_t num_msgs,

        // Outgoing stream
        output logic   val,
        input  logic   rdy,
        output msg_t   msg,

        // High once all messages have gone out
        output logic   done
);

        // ----------------------------------------------------------------------
        // Storage
        // ----------------------------------------------------------------------

        msg_t          src_mem [0:`HARNESS_MAX_MSGS-1];

        source_state_e state;
        index_t        index;
        count_t        msg_total;

        // Host writes aimed at this memory
        always_ff @(posedge clk) begin
                if (load.en && load.target == load_source) begin
                        src_mem[load.addr] <= load.data;
                end
        end

        // ----------------------------------------------------------------------
        // Stream side
        // ----------------------------------------------------------------------

        logic go;
        logic last_xfer;

        // val depends only on state, never on rdy
        assign val  = (state == src_send);
        assign msg  = src_mem[index];
        assign done = (state == src_done);

        assign go        = val && rdy;
        // Index widened to count width for the compare
        assign last_xfer = ({1'b0, index} == msg_total - count_t'(1));

        // Count latched on start so the host may change it mid-run
        always_ff @(posedge clk) begin
                if (start) begin
                        msg_total <= num_msgs;
                end
        end

        always_ff @(posedge clk) begin
                if (!reset) begin
                        state <= src_idle;
                        index <= '0;
                end else if (start) begin
                        // Restart from any state
                        index <= '0;
                        state <= (num_msgs == '0) ? src_done : src_send;
                end else if (go) begin
                        index <= index + index_t'(1);
                        if (last_xfer) begin
                                state <= src_done;
                        end
                end
        end

endmodule

// File: hw/load_if.sv
// Host write port into the source and sink memories
// No handshake, each write is a one-cycle strobe on en
`timescale 1ns/1ps

interface load_if;

        // Write strobe, memory selected by target
        logic                           en;
        harness_ctrl_pkg::load_target_e target;
        stream_pkg::index_t             addr;
        stream_pkg::msg_t               data;

        // Host side drives the write
        modport host (output en, output target, output addr, output data);

        // Each memory only listens
        modport mem (input en, input target, input addr, input data);

endinterface

// File: hw/harness_ctrl_pkg.sv
// Control encodings for the load bus and the two state machines
// Load target is a single bit, only source and sink memories exist

package harness_ctrl_pkg;

        // Memory selected by a load bus write
        typedef enum logic {
                load_source = 1'b0,
                load_sink   = 1'b1
        } load_target_e;

        // Source FSM, done is held until the next start
        typedef enum logic [1:0] {src_idle, src_send, src_done} source_state_e;

        // Sink FSM, same shape as the source
        typedef enum logic [1:0] {snk_idle, snk_recv, snk_done} sink_state_e;

endpackage

// File: hw/stream_pkg.sv
// Data types carried on the stream and used to address the memories
// count_t is one bit wider than index_t so a full memory can be counted

`include "harness_cfg.svh"

package stream_pkg;

        // One message on the val/rdy stream
        typedef logic [`HARNESS_MSG_NBITS-1:0] msg_t;

        // Address into a source or sink memory
        typedef logic [$clog2(`HARNESS_MAX_MSGS)-1:0] index_t;

        // Message count and counter width, holds 0 up to HARNESS_MAX_MSGS
        typedef logic [$clog2(`HARNESS_MAX_MSGS):0] count_t;

endpackage

// File: hw/harness_cfg.svh
// Build-time sizes shared by the packages and the RTL
// Memory depth must be a power of two so index_t covers every entry
// Stall seed must be nonzero or the sink LFSR locks up
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// Width of one stream message in bits
`define HARNESS_MSG_NBITS 16

// Entries in each of the source and sink memories
`define HARNESS_MAX_MSGS 64

// Reset value of the 16-bit sink stall LFSR
`define HARNESS_STALL_SEED 16'hace1

`endif
